//--- logic/core_settings.svh
// core-wide widths and the reset pc, included by the packages and the fetch unit
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define CORE_XLEN 32

// integer register file
`define CORE_REG_COUNT 32
`define CORE_REG_IDX_W 5

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- logic/rv_isa_pkg.sv
// RV32 encodings, instruction formats and immediate builders, imported by the decode unit
`include "core_settings.svh"

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b001_0011,
		OPC_AUIPC  = 7'b001_0111,
		OPC_LUI    = 7'b011_0111,
		OPC_JAL    = 7'b110_1111,
		OPC_JALR   = 7'b110_0111,
		OPC_STORE  = 7'b010_0011,
		OPC_SYSTEM = 7'b111_0011
	} opcode_e;

	localparam logic [2:0] F3_ADDI = 3'b000;
	localparam logic [2:0] F3_JALR = 3'b000;
	localparam logic [2:0] F3_SW   = 3'b010;
	localparam logic [2:0] F3_PRIV = 3'b000;

	// imm field of ebreak, ecall has zero here
	localparam logic [11:0] EBREAK_IMM = 12'h001;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	// jal immediate is scrambled in the word
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		logic [31:0] raw;
		i_fmt_t      i;
		s_fmt_t      s;
		u_fmt_t      u;
		j_fmt_t      j;
	} inst_word_u;

	function automatic logic [`CORE_XLEN-1:0] imm_i(inst_word_u inst);
		return {{(`CORE_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	endfunction

	function automatic logic [`CORE_XLEN-1:0] imm_s(inst_word_u inst);
		return {{(`CORE_XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
	endfunction

	function automatic logic [`CORE_XLEN-1:0] imm_u(inst_word_u inst);
		return {inst.u.imm, 12'b0};
	endfunction

	function automatic logic [`CORE_XLEN-1:0] imm_j(inst_word_u inst);
		return {{(`CORE_XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
			inst.j.imm_11, inst.j.imm_10_1, 1'b0};
	endfunction

endpackage

//--- logic/core_bus_pkg.sv
// AXI4-Lite channel payloads and the records passed between core stages
`include "core_settings.svh"

package core_bus_pkg;

	typedef logic [`CORE_XLEN-1:0]      word_t;
	typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

	localparam int unsigned REG_COUNT = `CORE_REG_COUNT;
	localparam int unsigned STRB_W    = `CORE_XLEN / 8;

	// axi4-lite channels
	typedef struct packed {
		word_t      addr;
		logic [2:0] prot;
	} axil_ar_t;

	typedef struct packed {
		word_t      data;
		logic [1:0] resp;
	} axil_r_t;

	typedef struct packed {
		word_t      addr;
		logic [2:0] prot;
	} axil_aw_t;

	typedef struct packed {
		word_t             data;
		logic [STRB_W-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	// stage records
	typedef struct packed {
		word_t inst;
		word_t pc;
	} fetch_out_t;

	typedef struct packed {
		word_t    src1;
		word_t    src2;
		word_t    store_data;
		reg_idx_t rd;
		logic     reg_wr;
		logic     jal;
		logic     jalr;
		logic     store;
		logic     ebreak;
	} decode_out_t;

	typedef struct packed {
		logic     reg_wen;
		reg_idx_t reg_idx;
		word_t    reg_data;
		word_t    next_pc;
		word_t    store_addr;
		word_t    store_data;
		logic     store;
		logic     halt;
	} exec_out_t;

endpackage

//--- logic/register_file.sv
// integer register file with two combinational reads, one write port and x0 held at zero
module register_file (
	input  logic                   clk,
	input  logic                   arst_n,
	input  core_bus_pkg::reg_idx_t raddr1,
	input  core_bus_pkg::reg_idx_t raddr2,
	output core_bus_pkg::word_t    rdata1,
	output core_bus_pkg::word_t    rdata2,
	input  logic                   wen,
	input  core_bus_pkg::reg_idx_t waddr,
	input  core_bus_pkg::word_t    wdata
);
	import core_bus_pkg::*;

	word_t regs [REG_COUNT];

	// x0 is cleared by reset and never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

//--- logic/fetch_unit.sv
// instruction fetch, keeps the pc and reads one instruction at a time over AXI4-Lite
`include "core_settings.svh"

module fetch_unit (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     commit,
	input  core_bus_pkg::word_t      next_pc,
	input  logic                     halt,
	output core_bus_pkg::axil_ar_t   ar,
	output logic                     arvalid,
	input  logic                     arready,
	input  core_bus_pkg::axil_r_t    r,
	input  logic                     rvalid,
	output logic                     rready,
	output core_bus_pkg::fetch_out_t fetched,
	output logic                     fetched_valid
);
	import core_bus_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_HOLD,
		ST_STOP
	} state_e;

	state_e state;
	word_t  pc;
	word_t  inst;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			pc    <= `CORE_RESET_PC;
		end else begin
			case (state)
				ST_IDLE: state <= ST_ADDR;
				ST_ADDR: begin
					if (arready) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (rvalid) begin
						state <= ST_HOLD;
					end
				end
				// instruction stays visible to decode until the store unit commits
				ST_HOLD: begin
					if (commit) begin
						pc    <= next_pc;
						state <= halt ? ST_STOP : ST_ADDR;
					end
				end
				default: state <= ST_STOP;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_DATA && rvalid) begin
			inst <= r.data;
		end
	end

	// prot marks an instruction access
	assign ar            = '{addr: pc, prot: 3'b100};
	assign arvalid       = (state == ST_ADDR);
	assign rready        = 1'b1;
	assign fetched       = '{inst: inst, pc: pc};
	assign fetched_valid = (state == ST_HOLD);

endmodule

//--- logic/decode_unit.sv
// instruction decode, classifies the held word and selects both adder sources
module decode_unit (
	input  logic                      clk,
	input  logic                      arst_n,
	input  core_bus_pkg::fetch_out_t  fetched,
	input  core_bus_pkg::exec_out_t   reg_wr,
	input  logic                      commit,
	output core_bus_pkg::decode_out_t decoded
);
	import rv_isa_pkg::*;
	import core_bus_pkg::*;

	inst_word_u inst;
	word_t      imm;
	word_t      rs1_data;
	word_t      rs2_data;
	logic       inst_addi;
	logic       inst_auipc;
	logic       inst_lui;
	logic       inst_jal;
	logic       inst_jalr;
	logic       inst_sw;
	logic       inst_ebreak;
	logic       src2_from_imm;

	assign inst = fetched.inst;

	assign inst_addi  = (inst.i.opcode == OPC_OP_IMM) && (inst.i.funct3 == F3_ADDI);
	assign inst_auipc = (inst.u.opcode == OPC_AUIPC);
	assign inst_lui   = (inst.u.opcode == OPC_LUI);
	assign inst_jal   = (inst.j.opcode == OPC_JAL);
	assign inst_jalr  = (inst.i.opcode == OPC_JALR) && (inst.i.funct3 == F3_JALR);
	assign inst_sw    = (inst.s.opcode == OPC_STORE) && (inst.s.funct3 == F3_SW);

	// only the exact ebreak encoding halts
	assign inst_ebreak = (inst.i.opcode == OPC_SYSTEM) && (inst.i.funct3 == F3_PRIV) &&
		(inst.i.imm == EBREAK_IMM) && (inst.i.rs1 == '0) && (inst.i.rd == '0);

	assign src2_from_imm = inst_addi || inst_auipc || inst_lui || inst_jal || inst_jalr ||
		inst_sw;

	always_comb begin
		if (inst_auipc || inst_lui) begin
			imm = imm_u(inst);
		end else if (inst_jal) begin
			imm = imm_j(inst);
		end else if (inst_sw) begin
			imm = imm_s(inst);
		end else begin
			imm = imm_i(inst);
		end
	end

	register_file u_register_file (
		.clk    (clk),
		.arst_n (arst_n),
		.raddr1 (inst.i.rs1),
		.raddr2 (inst.s.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.wen    (commit && reg_wr.reg_wen),
		.waddr  (reg_wr.reg_idx),
		.wdata  (reg_wr.reg_data)
	);

	always_comb begin
		// lui adds its immediate to zero
		if (inst_jal || inst_auipc) begin
			decoded.src1 = fetched.pc;
		end else if (inst_lui) begin
			decoded.src1 = '0;
		end else begin
			decoded.src1 = rs1_data;
		end
		decoded.src2       = src2_from_imm ? imm : rs2_data;
		decoded.store_data = rs2_data;
		decoded.rd         = inst.i.rd;
		decoded.reg_wr     = inst_addi || inst_auipc || inst_lui || inst_jal || inst_jalr;
		decoded.jal        = inst_jal;
		decoded.jalr       = inst_jalr;
		decoded.store      = inst_sw;
		decoded.ebreak     = inst_ebreak;
	end

endmodule

//--- logic/execute_unit.sv
// execute stage, one adder producing the result, the link value and the next pc
module execute_unit (
	input  core_bus_pkg::decode_out_t decoded,
	input  core_bus_pkg::word_t       pc,
	output core_bus_pkg::exec_out_t   result
);
	import core_bus_pkg::*;

	word_t sum;
	word_t pc_plus4;

	assign sum      = decoded.src1 + decoded.src2;
	assign pc_plus4 = pc + word_t'(4);

	always_comb begin
		result.reg_wen    = decoded.reg_wr;
		result.reg_idx    = decoded.rd;
		result.store_addr = sum;
		result.store_data = decoded.store_data;
		result.store      = decoded.store;
		result.halt       = decoded.ebreak;
		if (decoded.jal || decoded.jalr) begin
			// jumps link pc+4 and take the sum as target
			result.reg_data = pc_plus4;
			result.next_pc  = decoded.jalr ? (sum & ~word_t'(1)) : sum;
		end else begin
			result.reg_data = sum;
			result.next_pc  = pc_plus4;
		end
	end

endmodule

//--- logic/store_unit.sv
// store stage, issues a store as one AXI4-Lite write and commits every instruction
module store_unit (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  core_bus_pkg::exec_out_t result,
	output core_bus_pkg::axil_aw_t  aw,
	output logic                    awvalid,
	input  logic                    awready,
	output core_bus_pkg::axil_w_t   w,
	output logic                    wvalid,
	input  logic                    wready,
	input  core_bus_pkg::axil_b_t   b,
	input  logic                    bvalid,
	output logic                    bready,
	output logic                    commit
);
	import core_bus_pkg::*;

	logic aw_pending;
	logic w_pending;
	logic busy;
	logic wait_b;
	logic direct_commit;

	// response is only expected once both address and data went out
	assign wait_b = busy && !aw_pending && !w_pending;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aw_pending    <= 1'b0;
			w_pending     <= 1'b0;
			busy          <= 1'b0;
			direct_commit <= 1'b0;
		end else begin
			direct_commit <= start && !result.store;
			if (start && result.store) begin
				aw_pending <= 1'b1;
				w_pending  <= 1'b1;
				busy       <= 1'b1;
			end else begin
				if (awready) begin
					aw_pending <= 1'b0;
				end
				if (wready) begin
					w_pending <= 1'b0;
				end
				if (wait_b && bvalid) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// payload comes straight from execute, held stable by fetch until commit
	assign aw      = '{addr: result.store_addr, prot: 3'b000};
	assign w       = '{data: result.store_data, strb: '1};
	assign awvalid = aw_pending;
	assign wvalid  = w_pending;
	assign bready  = 1'b1;
	assign commit  = direct_commit || (wait_b && bvalid);

endmodule

//--- logic/rv_core_top.sv
// multicycle RV32 core top, one AXI4-Lite read port for fetch and one write port for stores
module rv_core_top (
	input  logic                   clk,
	input  logic                   arst_n,
	output core_bus_pkg::axil_ar_t ar,
	output logic                   arvalid,
	input  logic                   arready,
	input  core_bus_pkg::axil_r_t  r,
	input  logic                   rvalid,
	output logic                   rready,
	output core_bus_pkg::axil_aw_t aw,
	output logic                   awvalid,
	input  logic                   awready,
	output core_bus_pkg::axil_w_t  w,
	output logic                   wvalid,
	input  logic                   wready,
	input  core_bus_pkg::axil_b_t  b,
	input  logic                   bvalid,
	output logic                   bready,
	output logic                   halted
);
	import core_bus_pkg::*;

	fetch_out_t  fetched;
	logic        fetched_valid;
	logic        fetched_valid_q;
	decode_out_t decoded;
	exec_out_t   result;
	logic        start;
	logic        commit;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fetched_valid_q <= 1'b0;
			halted          <= 1'b0;
		end else begin
			fetched_valid_q <= fetched_valid;
			// sticky once ebreak commits
			if (commit && result.halt) begin
				halted <= 1'b1;
			end
		end
	end

	// new instruction present
	assign start = fetched_valid && !fetched_valid_q;

	fetch_unit u_fetch (
		.clk           (clk),
		.arst_n        (arst_n),
		.commit        (commit),
		.next_pc       (result.next_pc),
		.halt          (result.halt),
		.ar            (ar),
		.arvalid       (arvalid),
		.arready       (arready),
		.r             (r),
		.rvalid        (rvalid),
		.rready        (rready),
		.fetched       (fetched),
		.fetched_valid (fetched_valid)
	);

	decode_unit u_decode (
		.clk     (clk),
		.arst_n  (arst_n),
		.fetched (fetched),
		.reg_wr  (result),
		.commit  (commit),
		.decoded (decoded)
	);

	execute_unit u_execute (
		.decoded (decoded),
		.pc      (fetched.pc),
		.result  (result)
	);

	store_unit u_store (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.result  (result),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready),
		.commit  (commit)
	);

endmodule

//--- bench/axi_lite_memory.sv
// AXI4-Lite memory model for the core testbench, serves fetches from a backdoor array and logs stores
module axi_lite_memory #(
	parameter int unsigned WORDS     = 256,
	parameter int unsigned LOG_DEPTH = 32
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  int unsigned            max_stall,
	input  core_bus_pkg::axil_ar_t ar,
	input  logic                   arvalid,
	output logic                   arready,
	output core_bus_pkg::axil_r_t  r,
	output logic                   rvalid,
	input  logic                   rready,
	input  core_bus_pkg::axil_aw_t aw,
	input  logic                   awvalid,
	output logic                   awready,
	input  core_bus_pkg::axil_w_t  w,
	input  logic                   wvalid,
	output logic                   wready,
	output core_bus_pkg::axil_b_t  b,
	output logic                   bvalid,
	input  logic                   bready
);
	import core_bus_pkg::*;

	// instruction words, written by the testbench through the hierarchy
	logic [31:0] imem [WORDS];

	word_t       log_addr [LOG_DEPTH];
	word_t       log_data [LOG_DEPTH];
	logic [3:0]  log_strb [LOG_DEPTH];
	int unsigned log_count;
	int unsigned fetch_count;
	int unsigned overlap_count;

	word_t       rd_addr;
	logic        rd_pending;
	word_t       wr_addr;
	word_t       wr_data;
	logic [3:0]  wr_strb;
	logic        got_aw;
	logic        got_w;
	logic        b_pending;
	int unsigned ar_wait;
	int unsigned aw_wait;
	int unsigned w_wait;

	// length of the next ready gap, zero most of the time
	function automatic int unsigned stall_cycles(input int unsigned limit);
		if (limit == 0 || $urandom_range(2, 0) != 0) begin
			return 0;
		end
		return $urandom_range(limit, 1);
	endfunction

	initial begin
		arready = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		rvalid  = 1'b0;
		bvalid  = 1'b0;
		r       = '0;
		b       = '0;
	end

	// handshakes are sampled on the rising edge
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pending    <= 1'b0;
			got_aw        <= 1'b0;
			got_w         <= 1'b0;
			b_pending     <= 1'b0;
			log_count     <= 0;
			fetch_count   <= 0;
			overlap_count <= 0;
		end else begin
			if (arvalid && arready) begin
				rd_pending  <= 1'b1;
				rd_addr     <= ar.addr;
				fetch_count <= fetch_count + 1;
			end else if (rvalid && rready) begin
				rd_pending <= 1'b0;
			end
			// a fetch request while a store is still open
			if (arvalid && (awvalid || wvalid || got_aw || got_w)) begin
				overlap_count <= overlap_count + 1;
			end
			if (awvalid && awready) begin
				got_aw  <= 1'b1;
				wr_addr <= aw.addr;
			end
			if (wvalid && wready) begin
				got_w   <= 1'b1;
				wr_data <= w.data;
				wr_strb <= w.strb;
			end
			if (bvalid && bready) begin
				got_aw    <= 1'b0;
				got_w     <= 1'b0;
				b_pending <= 1'b0;
			end else if (got_aw && got_w && !b_pending) begin
				b_pending <= 1'b1;
				if (log_count < LOG_DEPTH) begin
					log_addr[log_count] <= wr_addr;
					log_data[log_count] <= wr_data;
					log_strb[log_count] <= wr_strb;
				end
				log_count <= log_count + 1;
			end
		end
	end

	// responses and ready change on the falling edge
	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
			r       <= '0;
			b       <= '0;
			ar_wait <= 0;
			aw_wait <= 0;
			w_wait  <= 0;
		end else begin
			if (ar_wait != 0) begin
				arready <= 1'b0;
				ar_wait <= ar_wait - 1;
			end else begin
				arready <= 1'b1;
				ar_wait <= stall_cycles(max_stall);
			end
			if (aw_wait != 0) begin
				awready <= 1'b0;
				aw_wait <= aw_wait - 1;
			end else begin
				awready <= 1'b1;
				aw_wait <= stall_cycles(max_stall);
			end
			if (w_wait != 0) begin
				wready <= 1'b0;
				w_wait <= w_wait - 1;
			end else begin
				wready <= 1'b1;
				w_wait <= stall_cycles(max_stall);
			end
			rvalid <= rd_pending;
			r      <= '{data: imem[(rd_addr >> 2) % WORDS], resp: 2'b00};
			bvalid <= b_pending;
			b      <= '{resp: 2'b00};
		end
	end

endmodule

//--- bench/core_tb.sv
// testbench for the RV32 core, runs small directed programs and checks the logged stores
module core_tb;
	import core_bus_pkg::*;

	localparam int unsigned CLK_PERIOD      = 20;
	localparam int unsigned NUM_TESTS       = 6;
	localparam int unsigned CYCLES_PER_TEST = 2000;
	localparam int unsigned IMEM_WORDS      = 256;
	localparam int unsigned LOG_DEPTH       = 32;
	localparam logic [31:0] EBREAK_WORD     = 32'h0010_0073;

	logic        clk;
	logic        arst_n;
	int unsigned max_stall;
	axil_ar_t    ar;
	logic        arvalid;
	logic        arready;
	axil_r_t     r;
	logic        rvalid;
	logic        rready;
	axil_aw_t    aw;
	logic        awvalid;
	logic        awready;
	axil_w_t     w;
	logic        wvalid;
	logic        wready;
	axil_b_t     b;
	logic        bvalid;
	logic        bready;
	logic        halted;

	int unsigned emit_addr;
	int unsigned exp_count;
	logic [31:0] exp_addr [LOG_DEPTH];
	logic [31:0] exp_data [LOG_DEPTH];

	rv_core_top i_dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready),
		.halted  (halted)
	);

	axi_lite_memory #(
		.WORDS     (IMEM_WORDS),
		.LOG_DEPTH (LOG_DEPTH)
	) i_mem (
		.clk       (clk),
		.arst_n    (arst_n),
		.max_stall (max_stall),
		.ar        (ar),
		.arvalid   (arvalid),
		.arready   (arready),
		.r         (r),
		.rvalid    (rvalid),
		.rready    (rready),
		.aw        (aw),
		.awvalid   (awvalid),
		.awready   (awready),
		.w         (w),
		.wvalid    (wvalid),
		.wready    (wready),
		.b         (b),
		.bvalid    (bvalid),
		.bready    (bready)
	);

	initial begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	// instruction encodings straight from the RV32I formats
	function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
	endfunction

	function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h67};
	endfunction

	function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'h37};
	endfunction

	function automatic logic [31:0] auipc(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'h17};
	endfunction

	function automatic logic [31:0] jal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	// unused words are addi x0 with the word index as immediate
	task automatic clear_program();
		@(negedge clk);
		for (int i = 0; i < IMEM_WORDS; i++) begin
			i_mem.imem[i] = addi(0, 0, i);
		end
		emit_addr = 0;
		exp_count = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		i_mem.imem[emit_addr] = word;
		emit_addr++;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr[exp_count] = addr;
		exp_data[exp_count] = data;
		exp_count++;
	endtask

	task automatic run_program(input int unsigned stall, input int unsigned fetches);
		@(negedge clk);
		max_stall = stall;
		arst_n    = 1'b0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		while (!halted) begin
			@(negedge clk);
		end
		repeat (20) @(negedge clk);
		check_value("halted", halted, 1);
		check_value("arvalid after halt", arvalid, 0);
		check_value("awvalid after halt", awvalid, 0);
		check_value("wvalid after halt", wvalid, 0);
		check_value("rready", rready, 1);
		check_value("bready", bready, 1);
		check_value("instruction fetches", i_mem.fetch_count, fetches);
		check_value("fetches during a store", i_mem.overlap_count, 0);
		check_value("store count", i_mem.log_count, exp_count);
		for (int i = 0; i < exp_count; i++) begin
			check_value($sformatf("store %0d address", i), i_mem.log_addr[i], exp_addr[i]);
			check_value($sformatf("store %0d data", i), i_mem.log_data[i], exp_data[i]);
			check_value($sformatf("store %0d strobe", i), i_mem.log_strb[i], 4'hf);
		end
	endtask

	task automatic addi_chain_test();
		int x1;
		int x2;
		int x3;
		clear_program();
		emit(addi(0, 0, 5));
		emit(addi(1, 0, 100));
		emit(addi(2, 1, -7));
		emit(addi(3, 2, -2048));
		emit(sw(0, 0, 'h100));
		emit(sw(2, 0, 'h104));
		emit(sw(3, 0, 'h108));
		emit(EBREAK_WORD);
		x1 = 100;
		x2 = x1 - 7;
		x3 = x2 - 2048;
		expect_store(32'h100, 0);
		expect_store(32'h104, x2);
		expect_store(32'h108, x3);
		run_program(3, 8);
	endtask

	task automatic upper_imm_test();
		clear_program();
		emit(lui(5, 'h12345));
		emit(auipc(6, 'hfffff));
		emit(auipc(7, 'h00001));
		emit(sw(5, 0, 'h40));
		emit(sw(6, 0, 'h44));
		emit(sw(7, 0, 'h48));
		emit(EBREAK_WORD);
		expect_store(32'h40, 32'h12345 << 12);
		expect_store(32'h44, (32'hfffff << 12) + 32'd4);
		expect_store(32'h48, (32'h00001 << 12) + 32'd8);
		run_program(3, 7);
	endtask

	// stores at 0x80..0x8c sit on skipped paths
	task automatic jump_test();
		clear_program();
		emit(jal(1, 12));
		emit(sw(0, 0, 'h80));
		emit(sw(0, 0, 'h84));
		emit(addi(2, 0, 28));
		emit(jalr(3, 2, 1));
		emit(sw(0, 0, 'h88));
		emit(sw(0, 0, 'h8c));
		// auipc at the jalr target exposes the pc it runs at
		emit(auipc(4, 0));
		emit(sw(1, 0, 'h90));
		emit(sw(3, 0, 'h94));
		emit(sw(4, 0, 'h98));
		emit(EBREAK_WORD);
		expect_store(32'h90, 32'd0 + 4);
		expect_store(32'h94, 32'd16 + 4);
		expect_store(32'h98, 32'd28);
		run_program(3, 8);
	endtask

	task automatic load_store_program();
		int base;
		clear_program();
		base = 'h400;
		emit(addi(1, 0, base));
		emit(addi(2, 0, -1));
		emit(addi(3, 0, 'h123));
		emit(sw(2, 1, -4));
		emit(sw(3, 1, -2048));
		emit(sw(1, 1, -16));
		emit(EBREAK_WORD);
		expect_store(base - 4, -1);
		expect_store(base - 2048, 'h123);
		expect_store(base - 16, base);
	endtask

	task automatic store_offset_test();
		load_store_program();
		run_program(3, 7);
	endtask

	task automatic backpressure_test();
		load_store_program();
		run_program(24, 7);
	endtask

	// the store after ebreak is never fetched
	task automatic ebreak_test();
		clear_program();
		emit(addi(1, 0, 1));
		emit(EBREAK_WORD);
		emit(sw(1, 0, 'h10));
		run_program(3, 2);
	endtask

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("timeout: the core never halted within %0d cycles",
			NUM_TESTS * CYCLES_PER_TEST);
		$display(">>> FAIL");
		$fatal(1);
	end

	initial begin
		void'($urandom(32'h5701));
		arst_n    = 1'b0;
		max_stall = 0;
		emit_addr = 0;
		exp_count = 0;
		addi_chain_test();
		upper_imm_test();
		jump_test();
		store_offset_test();
		backpressure_test();
		ebreak_test();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/core_bus_pkg.sv
logic/register_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/store_unit.sv
logic/rv_core_top.sv
bench/axi_lite_memory.sv
bench/core_tb.sv
